// File: design/xcorr_pkg.sv
package xcorr_pkg;

    // ========================================
    // sample and phase words
    // ========================================

    // one code from the 8-bit ADC, unsigned.
    typedef logic [7:0] adc_sample_t;

    // correlator phase, one of 64 steps per window.
    typedef logic [5:0] corr_phase_t;

    // window length in phase steps.
    localparam int phase_steps = 64;

    // running sum of square-wave products.
    typedef logic signed [13:0] corr_accum_t;

    // ========================================
    // output bytes
    // ========================================

    // snoop form of a byte. The lowest bit carries the carrier flag.
    typedef struct packed {
        logic signed [6:0] mag;
        logic              hyst_flag;
    } corr_tagged_t;

    // the same byte read either as a plain correlation value or in snoop form.
    typedef union packed {
        logic signed [7:0] plain;
        corr_tagged_t      tagged_byte;
    } corr_byte_u;

    // i_byte sits in the upper half and is shifted out first.
    typedef struct packed {
        corr_byte_u i_byte;
        corr_byte_u q_byte;
    } corr_result_t;

endpackage

// File: design/carrier_hysteresis.sv
module carrier_hysteresis (
    input  logic                   ck_1356megb,
    input  logic                   rst_n,
    input  xcorr_pkg::adc_sample_t adc_d,
    output logic                   carrier_present
);

    logic [11:0] low_count;   // samples seen while the level is low.
    logic        full_scale;
    logic        zero_scale;
    logic        low_expired;

    assign full_scale  = &adc_d;
    assign zero_scale  = ~|adc_d;
    assign low_expired = (low_count == 12'hfff);   // this is the 4096th low sample.

    always_ff @(posedge ck_1356megb or negedge rst_n)
    begin
        if (!rst_n)
        begin
            carrier_present <= 1'b1;
            low_count       <= '0;
        end
        else if (carrier_present)
        begin
            low_count <= '0;
            if (zero_scale)
                carrier_present <= 1'b0;
        end
        else if (low_expired)
        begin
            // a missed full-scale code must not hold the flag low forever.
            carrier_present <= 1'b1;
            low_count       <= '0;
        end
        else
        begin
            low_count <= low_count + 12'd1;
            if (full_scale)
                carrier_present <= 1'b1;
        end
    end

endmodule

// File: design/iq_correlator.sv
module iq_correlator (
    input  logic                    ck_1356megb,
    input  logic                    rst_n,
    input  xcorr_pkg::adc_sample_t  adc_d,
    input  logic                    xcorr_is_848,
    input  logic                    snoop,
    input  logic                    carrier_present,
    output xcorr_pkg::corr_phase_t  phase,
    output xcorr_pkg::corr_result_t result,
    output logic                    result_load
);

    localparam xcorr_pkg::corr_phase_t mid_phase =
        xcorr_pkg::corr_phase_t'(xcorr_pkg::phase_steps / 2);

    logic                   fc_div_2;
    logic                   advance;
    logic                   window_start;
    logic                   i_neg;
    logic                   q_neg;
    xcorr_pkg::corr_accum_t sample_ext;
    xcorr_pkg::corr_accum_t i_accum;
    xcorr_pkg::corr_accum_t q_accum;
    logic                   carrier_two_back;   // level taken at the last window start.
    logic                   carrier_mid;        // level taken halfway through the last window.

    // ========================================
    // phase stepping
    // ========================================

    assign advance      = xcorr_is_848 | fc_div_2;   // 424 kHz steps on alternate clocks.
    assign window_start = (phase == '0) && advance;
    assign result_load  = window_start;

    always_ff @(posedge ck_1356megb or negedge rst_n)
    begin
        if (!rst_n)
        begin
            fc_div_2 <= 1'b0;
            phase    <= '0;
        end
        else
        begin
            fc_div_2 <= ~fc_div_2;
            if (advance)
                phase <= phase + 6'd1;
        end
    end

    // ========================================
    // square-wave products
    // ========================================

    assign sample_ext = {6'd0, adc_d};
    assign i_neg      = phase[3];
    assign q_neg      = (phase[3] != phase[2]);   // quadrature leads by a quarter period.

    always_ff @(posedge ck_1356megb or negedge rst_n)
    begin
        if (!rst_n)
        begin
            i_accum <= '0;
            q_accum <= '0;
        end
        else if (window_start)
        begin
            i_accum <= sample_ext;
            q_accum <= sample_ext;
        end
        else
        begin
            i_accum <= i_neg ? i_accum - sample_ext : i_accum + sample_ext;
            q_accum <= q_neg ? q_accum - sample_ext : q_accum + sample_ext;
        end
    end

    always_ff @(posedge ck_1356megb or negedge rst_n)
    begin
        if (!rst_n)
        begin
            carrier_two_back <= 1'b1;
            carrier_mid      <= 1'b1;
        end
        else
        begin
            if (window_start)
                carrier_two_back <= carrier_present;
            if (advance && (phase == mid_phase))
                carrier_mid <= carrier_present;
        end
    end

    // bytes are read off the accumulators on the window_start clock.
    always_comb
    begin
        if (snoop)
        begin
            result.i_byte.tagged_byte.mag       = i_accum[13:7];
            result.i_byte.tagged_byte.hyst_flag = carrier_two_back;
            result.q_byte.tagged_byte.mag       = q_accum[13:7];
            result.q_byte.tagged_byte.hyst_flag = carrier_mid;
        end
        else
        begin
            result.i_byte.plain = i_accum[13:6];
            result.q_byte.plain = q_accum[13:6];
        end
    end

endmodule

// File: design/ssp_serializer.sv
module ssp_serializer (
    input  logic                    ck_1356megb,
    input  logic                    rst_n,
    input  xcorr_pkg::corr_phase_t  phase,
    input  xcorr_pkg::corr_result_t result,
    input  logic                    result_load,
    output logic                    ssp_din,
    output logic                    ssp_clk,
    output logic                    ssp_frame
);

    localparam int         shift_bits  = $bits(xcorr_pkg::corr_result_t);
    localparam logic [3:0] mid_quarter = 4'(xcorr_pkg::phase_steps / 8);

    logic [shift_bits-1:0]  shift_reg;
    xcorr_pkg::corr_phase_t phase_q;
    logic                   phase_entered;
    logic                   shift_step;
    logic                   clk_rise;
    logic                   frame_phase;

    // in 424 mode each phase lasts two clocks, so act on its first one only.
    assign phase_entered = (phase != phase_q);
    assign shift_step    = phase_entered && (phase[1:0] == 2'b00) && (phase != '0);
    assign clk_rise      = result_load | shift_step;
    assign frame_phase   = (phase[5:2] == 4'd0) || (phase[5:2] == mid_quarter);

    always_ff @(posedge ck_1356megb or negedge rst_n)
    begin
        if (!rst_n)
        begin
            shift_reg <= '0;
            phase_q   <= '0;
            ssp_clk   <= 1'b0;
            ssp_frame <= 1'b0;
        end
        else
        begin
            phase_q <= phase;
            if (result_load)
                shift_reg <= result;   // i byte goes out first.
            else if (shift_step)
                shift_reg <= {shift_reg[shift_bits-2:0], 1'b0};
            if (clk_rise)
            begin
                ssp_clk   <= 1'b1;
                ssp_frame <= frame_phase;   // frame edges line up with clock rises.
            end
            else if (phase[1:0] == 2'b10)
                ssp_clk <= 1'b0;
        end
    end

    assign ssp_din = shift_reg[shift_bits-1];

endmodule

// File: design/hi_read_rx_xcorr.sv
module hi_read_rx_xcorr (
    input  logic                   ck_1356megb,
    input  logic                   rst_n,
    input  xcorr_pkg::adc_sample_t adc_d,
    input  logic                   xcorr_is_848,
    input  logic                   snoop,
    output logic                   adc_clk,
    output logic                   pwr_lo,
    output logic                   pwr_hi,
    output logic                   pwr_oe1,
    output logic                   pwr_oe2,
    output logic                   pwr_oe3,
    output logic                   pwr_oe4,
    output logic                   ssp_din,
    output logic                   ssp_clk,
    output logic                   ssp_frame,
    output logic                   dbg
);

    logic                    carrier_present;
    logic                    result_load;
    xcorr_pkg::corr_phase_t  phase;
    xcorr_pkg::corr_result_t result;

    // ========================================
    // antenna driver pins
    // ========================================

    // the reader field is off in snoop mode.
    assign pwr_hi  = ck_1356megb & ~snoop;
    assign pwr_lo  = 1'b0;
    assign pwr_oe1 = 1'b0;
    assign pwr_oe2 = 1'b0;
    assign pwr_oe3 = 1'b0;
    assign pwr_oe4 = 1'b0;
    assign adc_clk = ck_1356megb;
    assign dbg     = phase[3];   // toggles at the I square-wave rate.

    // ========================================
    // receive chain
    // ========================================

    carrier_hysteresis u_hyst (
        .ck_1356megb     (ck_1356megb),
        .rst_n           (rst_n),
        .adc_d           (adc_d),
        .carrier_present (carrier_present)
    );

    iq_correlator u_corr (
        .ck_1356megb     (ck_1356megb),
        .rst_n           (rst_n),
        .adc_d           (adc_d),
        .xcorr_is_848    (xcorr_is_848),
        .snoop           (snoop),
        .carrier_present (carrier_present),
        .phase           (phase),
        .result          (result),
        .result_load     (result_load)
    );

    ssp_serializer u_ssp (
        .ck_1356megb (ck_1356megb),
        .rst_n       (rst_n),
        .phase       (phase),
        .result      (result),
        .result_load (result_load),
        .ssp_din     (ssp_din),
        .ssp_clk     (ssp_clk),
        .ssp_frame   (ssp_frame)
    );

endmodule

// File: testbench/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int reset_cycles = 5;

    initial
    begin
        clk   = 1'b0;
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;   // released on a rising edge, like the drive of every other input.
    end

    always #10 clk = ~clk;   // 20 ns period.

endmodule

// File: testbench/hi_read_rx_xcorr_properties.sv
module hi_read_rx_xcorr_properties (
    input logic ck_1356megb,
    input logic rst_n,
    input logic snoop,
    input logic ssp_clk,
    input logic ssp_frame,
    input logic pwr_lo,
    input logic pwr_hi,
    input logic pwr_oe1,
    input logic pwr_oe2,
    input logic pwr_oe3,
    input logic pwr_oe4
);
    timeunit 1ns;
    timeprecision 100ps;

    // the host latches the frame on the same clock rise.
    frame_on_clock_rise: assert property (@(posedge ck_1356megb) disable iff (!rst_n)
        $rose(ssp_frame) |-> $rose(ssp_clk))
        else $error("ssp_frame rose without a rising ssp_clk");

    driver_pins_low: assert property (@(posedge ck_1356megb) disable iff (!rst_n)
        !(pwr_lo | pwr_oe1 | pwr_oe2 | pwr_oe3 | pwr_oe4))
        else $error("a low-side or output-enable power pin was driven high");

    // sampled on the falling edge, so pwr_hi is seen while the carrier clock is high.
    field_off_in_snoop: assert property (@(negedge ck_1356megb) disable iff (!rst_n)
        snoop |-> !pwr_hi)
        else $error("pwr_hi was driven while snoop was set");

endmodule

bind hi_read_rx_xcorr hi_read_rx_xcorr_properties u_props (.*);

// File: testbench/tb_hi_read_rx_xcorr.sv
module tb_hi_read_rx_xcorr;
    timeunit 1ns;
    timeprecision 100ps;

    logic                   ck_1356megb;
    logic                   rst_n;
    xcorr_pkg::adc_sample_t adc_d;
    logic                   xcorr_is_848;
    logic                   snoop;
    logic                   adc_clk;
    logic                   pwr_lo, pwr_hi, pwr_oe1, pwr_oe2, pwr_oe3, pwr_oe4;
    logic                   ssp_din, ssp_clk, ssp_frame, dbg;

    // ========================================
    // stimulus state
    // ========================================

    xcorr_pkg::corr_phase_t ph;             // phase the DUT holds for its next edge.
    logic                   div;
    logic                   cur_848;        // mode that the DUT sees on its next edge.
    logic                   test_848;
    logic                   test_snoop;
    string                  pat_code;
    logic [7:0]             pat_value;
    int                     sample_index;
    logic                   clk_prev, frame_prev, dbg_prev;
    logic                   clk_rose, frame_rose, dbg_moved;

    tb_clock_gen u_clk (.clk(ck_1356megb), .rst_n(rst_n));

    hi_read_rx_xcorr UUT (.*);

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_result(string test, xcorr_pkg::corr_result_t exp,
                                xcorr_pkg::corr_result_t act);
        if (act !== exp)
        begin
            $display("[FAIL] %s: result expected %h actual %h", test, exp, act);
            abort_run();
        end
    endtask

    task automatic check_bit(string test, string what, logic exp, logic act);
        if (act !== exp)
        begin
            $display("[FAIL] %s: %s expected %b actual %b", test, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_count(string test, string what, int exp, int act);
        if (act != exp)
        begin
            $display("[FAIL] %s: %s expected %0d actual %0d", test, what, exp, act);
            abort_run();
        end
    endtask

    function automatic xcorr_pkg::adc_sample_t pattern_sample(xcorr_pkg::corr_phase_t p);
        if (pat_code == "S")
            return p[3] ? 8'h80 - pat_value : 8'h80 + pat_value;   // in phase with I.
        else if (pat_code == "D")
            return (sample_index == 0) ? 8'h00 : pat_value;
        else if (pat_code == "R")
            return xcorr_pkg::adc_sample_t'($urandom());
        return pat_value;
    endfunction

    // one carrier clock: drive on the rising edge, look at the strobes on the falling one.
    task automatic tick(string test);
        @(posedge ck_1356megb);
        if (cur_848 || div)
            ph = ph + 6'd1;
        div = ~div;
        adc_d        <= pattern_sample(ph);
        xcorr_is_848 <= test_848;
        snoop        <= test_snoop;
        cur_848      = test_848;
        sample_index++;
        #2;
        // adc_clk follows the carrier clock and pwr_hi does so only while the field is on.
        check_bit(test, "adc_clk high phase", 1'b1, adc_clk);
        check_bit(test, "pwr_hi high phase", !test_snoop, pwr_hi);
        @(negedge ck_1356megb);
        clk_rose   = ssp_clk && !clk_prev;
        frame_rose = ssp_frame && !frame_prev;
        dbg_moved  = (dbg != dbg_prev);
        clk_prev   = ssp_clk;
        frame_prev = ssp_frame;
        dbg_prev   = dbg;
        #2;
        check_bit(test, "adc_clk low phase", 1'b0, adc_clk);
        check_bit(test, "pwr_hi low phase", 1'b0, pwr_hi);
    endtask

    task automatic run_test(string name, int m848, int snp, string code, logic [7:0] value,
                            int windows, logic [7:0] exp_i, logic [7:0] exp_q);
        int         win_ticks;
        int         n;
        int         rises;
        int         frames;
        int         toggles;
        int         second_frame_at;
        logic [15:0] bits;
        test_848     = (m848 != 0);
        test_snoop   = (snp != 0);
        pat_code     = code;
        pat_value    = value;
        sample_index = 0;
        win_ticks    = xcorr_pkg::phase_steps * (test_848 ? 1 : 2);
        repeat (windows * win_ticks) tick(name);
        // the frame that opens the I byte follows the phase-0 load.
        n = 0;
        do
        begin
            tick(name);
            n++;
        end
        while (!(frame_rose && ph == 6'd1) && n < 3 * win_ticks);
        if (!(frame_rose && ph == 6'd1))
        begin
            $display("%s: no frame arrived within three windows", name);
            abort_run();
        end
        check_bit(name, "ssp_clk rise with frame", 1'b1, clk_rose);
        bits            = {15'd0, ssp_din};
        rises           = 1;
        frames          = 1;
        toggles         = 0;
        second_frame_at = -1;
        repeat (win_ticks - 1)
        begin
            tick(name);
            if (dbg_moved)
                toggles++;
            if (frame_rose)
            begin
                frames++;
                second_frame_at = rises;
            end
            if (clk_rose)
            begin
                if (rises < 16)
                    bits = {bits[14:0], ssp_din};
                rises++;
            end
        end
        check_count(name, "ssp_clk rises per window", 16, rises);
        check_count(name, "frames per window", 2, frames);
        check_count(name, "clock rise of second frame", 8, second_frame_at);
        check_count(name, "dbg toggles per window", 8, toggles);
        if (code != "R")
            check_result(name, xcorr_pkg::corr_result_t'({exp_i, exp_q}),
                         xcorr_pkg::corr_result_t'(bits));
    endtask

    // ========================================
    // test sequence
    // ========================================

    initial
    begin
        int         fd;
        int         n;
        int         n_tests;
        string      line;
        string      name;
        string      code;
        int         m848;
        int         snp;
        int         windows;
        logic [7:0] value;
        logic [7:0] exp_i;
        logic [7:0] exp_q;
        adc_d        = '0;
        xcorr_is_848 = 1'b1;
        snoop        = 1'b0;
        void'($urandom(32'hacca7301));
        ph           = '0;
        div          = 1'b0;
        cur_848      = 1'b1;
        test_848     = 1'b1;
        test_snoop   = 1'b0;
        pat_code     = "C";
        pat_value    = 8'h00;
        n_tests      = 0;
        fd = $fopen("testbench/xcorr_golden.txt", "r");
        if (fd == 0)
        begin
            $display("the golden file testbench/xcorr_golden.txt could not be opened");
            abort_run();
        end
        for (n = 0; n < 20 && rst_n !== 1'b1; n++)
            @(negedge ck_1356megb);
        if (rst_n !== 1'b1)
        begin
            $display("reset was never released");
            abort_run();
        end
        check_bit("reset", "ssp_clk", 1'b0, ssp_clk);
        check_bit("reset", "ssp_frame", 1'b0, ssp_frame);
        check_bit("reset", "ssp_din", 1'b0, ssp_din);
        check_bit("reset", "dbg", 1'b0, dbg);
        clk_prev   = ssp_clk;
        frame_prev = ssp_frame;
        dbg_prev   = dbg;
        while ($fgets(line, fd) != 0)
        begin
            // comment lines fail the field count and are passed over.
            if ($sscanf(line, "%s %d %d %s %h %d %h %h", name, m848, snp, code, value,
                        windows, exp_i, exp_q) == 8)
            begin
                run_test(name, m848, snp, code, value, windows, exp_i, exp_q);
                n_tests++;
            end
        end
        $fclose(fd);
        if (n_tests == 0)
        begin
            $display("no test lines were found in the golden file");
            abort_run();
        end
        else
        begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

// File: testbench/xcorr_golden.txt
# name  is_848  snoop  code  value  windows  exp_i  exp_q
# code: C constant, S square 0x80+-value, D one 0x00 then value, R random (bytes unchecked)
const_zero      1 0 C 00 3  00 00
const_mid       1 0 C 80 3  00 00
const_full      1 0 C ff 3  00 00
square_848      1 0 S 20 3  20 00
square_424      0 0 S 20 3  40 00
snoop_full      1 1 C ff 3  01 01
snoop_drop      1 1 D 80 3  00 00
snoop_timeout   0 1 C 80 33 01 01
random_848      1 0 R 00 3  00 00
random_424      0 0 R 00 3  00 00

// File: list.f
design/xcorr_pkg.sv
design/carrier_hysteresis.sv
design/iq_correlator.sv
design/ssp_serializer.sv
design/hi_read_rx_xcorr.sv
testbench/tb_clock_gen.sv
testbench/hi_read_rx_xcorr_properties.sv
testbench/tb_hi_read_rx_xcorr.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_hi_read_rx_xcorr
FILE_LIST = list.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
FAIL_MSG  = Done: errors found
PASS_MSG  = Done: no errors
SOURCES   = $(shell cat $(FILE_LIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
